// File: include/flash_defs.svh
`ifndef FLASH_DEFS_SVH
`define FLASH_DEFS_SVH

// Write FIFO entries
`define FLASH_FIFO_DEPTH 16

// Register map
`define REG_ADDR_BITS 2
`define REG_CNTRL     2'd0
`define REG_ADDR      2'd1
`define REG_DATA      2'd2

// Serial NOR opcodes
`define OP_WREN 8'h06
`define OP_SE   8'h20
`define OP_BE   8'hD8
`define OP_CE   8'hC7
`define OP_PP   8'h02
`define OP_READ 8'h03
`define OP_RDSR 8'h05
`define OP_WRSR 8'h01

// Bits per SPI phase
`define SPI_OP_BITS   8
`define SPI_ADDR_BITS 24
`define SPI_DATA_BITS 8

`endif

// File: hdl/flashPkg.sv
package flashPkg;

    typedef enum logic [3:0] {
        CmdWriteEnable = 4'd0,
        CmdSectorErase = 4'd1,
        CmdBlockErase  = 4'd2,
        CmdChipErase   = 4'd3,
        CmdProgramPage = 4'd4,
        CmdRead        = 4'd5,
        CmdReadStatus  = 4'd6,
        CmdWriteStatus = 4'd7
    } flashCmd_t;

    // Handed to the controller with the start pulse
    typedef struct packed {
        flashCmd_t   cmd;
        logic [23:0] addr;
    } flashReq_t;

    // Control register as written by the host
    typedef struct packed {
        logic [22:0] reserved1;
        logic        start;
        logic [3:0]  reserved0;
        flashCmd_t   cmd;
    } ctrlWrite_t;

    // Control register as read back
    typedef struct packed {
        logic [19:0] zero1;
        logic        fifoEmpty;
        logic        fifoFull;
        logic        cmdBusy;
        logic        startPending;
        logic [3:0]  zero0;
        flashCmd_t   cmd;
    } ctrlStatus_t;

endpackage

// File: hdl/flashWriteFifo.sv
`timescale 1ns/1ps
`include "flash_defs.svh"

module flashWriteFifo (
    input  logic       i_Clk,
    input  logic       i_rstN,
    input  logic [7:0] i_Din,
    input  logic       i_WrEn,
    input  logic       i_RdEn,
    output logic [7:0] o_Dout,
    output logic       o_Full,
    output logic       o_Empty
);

    localparam int PTR_BITS = $clog2(`FLASH_FIFO_DEPTH);

    logic [7:0]          mem [`FLASH_FIFO_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS:0]   count;
    logic                doPush;
    logic                doPop;

    assign o_Full  = (count == (PTR_BITS+1)'(`FLASH_FIFO_DEPTH));
    assign o_Empty = (count == '0);
    assign doPush  = i_WrEn && !o_Full;
    assign doPop   = i_RdEn && !o_Empty;

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pointers wrap since the depth is a power of two
    always_ff @(posedge i_Clk) begin
        if (doPush) begin
            mem[wrPtr] <= i_Din;
        end
        if (doPop) begin
            o_Dout <= mem[rdPtr];
        end
    end

    noPopWhenEmpty: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        i_RdEn |-> !o_Empty);

    fullPushDropped: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        i_WrEn && o_Full && !i_RdEn |=> $stable(count));

endmodule

// File: hdl/flashController.sv
`timescale 1ns/1ps
`include "flash_defs.svh"

module flashController import flashPkg::*; (
    input  logic       i_Clk,
    input  logic       i_rstN,
    input  logic       i_Start,
    input  flashReq_t  i_Req,
    input  logic [7:0] i_WriteData,
    input  logic       i_AckReq,
    output logic [7:0] o_ReadData,
    output logic       o_ReqNextData,
    output logic       o_CMDBusy,
    output logic       o_Flash_Clk,
    output logic       o_Flash_nCS,
    inout  wire  [3:0] io_Flash_IO
);

    localparam int SHIFT_BITS = `SPI_OP_BITS + `SPI_ADDR_BITS;
    localparam int CNT_BITS   = $clog2(`SPI_ADDR_BITS);

    typedef enum logic [2:0] {
        StIdle, StOpcode, StAddr, StDataOut, StDataIn, StDone
    } spiState_t;

    spiState_t             state;
    spiState_t             nextState;
    flashCmd_t             curCmd;
    logic [SHIFT_BITS-1:0] shiftReg;
    logic [CNT_BITS-1:0]   bitCnt;
    logic [7:0]            rxByte;
    logic                  haveByte;
    logic                  ackWait;
    logic                  needAddr;
    logic                  needOut;
    logic                  needIn;
    logic                  moreOut;

    function automatic logic [7:0] cmdOpcode(input flashCmd_t cmd);
        case (cmd)
            CmdWriteEnable: cmdOpcode = `OP_WREN;
            CmdSectorErase: cmdOpcode = `OP_SE;
            CmdBlockErase:  cmdOpcode = `OP_BE;
            CmdChipErase:   cmdOpcode = `OP_CE;
            CmdProgramPage: cmdOpcode = `OP_PP;
            CmdRead:        cmdOpcode = `OP_READ;
            CmdWriteStatus: cmdOpcode = `OP_WRSR;
            default:        cmdOpcode = `OP_RDSR;
        endcase
    endfunction

    // Phases each command goes through after the opcode
    always_comb begin
        needAddr = 1'b0;
        needOut  = 1'b0;
        needIn   = 1'b0;
        moreOut  = 1'b0;
        case (curCmd)
            CmdSectorErase, CmdBlockErase: needAddr = 1'b1;
            CmdProgramPage: begin
                needAddr = 1'b1;
                needOut  = 1'b1;
                moreOut  = 1'b1;
            end
            CmdRead: begin
                needAddr = 1'b1;
                needIn   = 1'b1;
            end
            CmdReadStatus:  needIn = 1'b1;
            CmdWriteStatus: needOut = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        nextState = StDone;
        if (state == StOpcode && needAddr) begin
            nextState = StAddr;
        end else if ((state == StOpcode || state == StAddr) && needOut) begin
            nextState = StDataOut;
        end else if ((state == StOpcode || state == StAddr) && needIn) begin
            nextState = StDataIn;
        end
    end

    assign o_ReqNextData   = (state == StDataOut) && !haveByte;
    assign io_Flash_IO[0]  = shiftReg[SHIFT_BITS-1];
    assign io_Flash_IO[1]  = 1'bz;
    // WP# and HOLD# held inactive
    assign io_Flash_IO[3:2] = 2'b11;

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            state       <= StIdle;
            curCmd      <= CmdWriteEnable;
            bitCnt      <= '0;
            haveByte    <= 1'b0;
            ackWait     <= 1'b0;
            o_ReadData  <= '0;
            o_CMDBusy   <= 1'b0;
            o_Flash_Clk <= 1'b0;
            o_Flash_nCS <= 1'b1;
        end else begin
            case (state)
                StIdle: begin
                    if (i_Start) begin
                        curCmd      <= i_Req.cmd;
                        shiftReg    <= {cmdOpcode(i_Req.cmd), i_Req.addr};
                        bitCnt      <= CNT_BITS'(`SPI_OP_BITS - 1);
                        o_CMDBusy   <= 1'b1;
                        o_Flash_nCS <= 1'b0;
                        state       <= StOpcode;
                    end
                end
                StOpcode, StAddr, StDataIn: begin
                    o_Flash_Clk <= !o_Flash_Clk;
                    if (!o_Flash_Clk) begin
                        rxByte <= {rxByte[6:0], io_Flash_IO[1]};
                    end else begin
                        // Falling serial clock moves the next bit out
                        shiftReg <= shiftReg << 1;
                        bitCnt   <= bitCnt - 1'b1;
                        if (bitCnt == '0) begin
                            state    <= nextState;
                            haveByte <= 1'b0;
                            ackWait  <= 1'b0;
                            bitCnt   <= (nextState == StAddr) ? CNT_BITS'(`SPI_ADDR_BITS - 1)
                                                              : CNT_BITS'(`SPI_DATA_BITS - 1);
                            if (state == StDataIn) begin
                                o_ReadData <= rxByte;
                            end
                        end
                    end
                end
                StDataOut: begin
                    if (!haveByte) begin
                        // Interface answers one cycle after the request
                        ackWait <= 1'b1;
                        if (ackWait) begin
                            if (i_AckReq) begin
                                shiftReg[SHIFT_BITS-1 -: `SPI_DATA_BITS] <= i_WriteData;
                                haveByte <= 1'b1;
                                bitCnt   <= CNT_BITS'(`SPI_DATA_BITS - 1);
                            end else begin
                                state <= StDone;
                            end
                        end
                    end else begin
                        o_Flash_Clk <= !o_Flash_Clk;
                        if (o_Flash_Clk) begin
                            shiftReg <= shiftReg << 1;
                            bitCnt   <= bitCnt - 1'b1;
                            if (bitCnt == '0) begin
                                haveByte <= 1'b0;
                                ackWait  <= 1'b0;
                                if (!moreOut) begin
                                    state <= StDone;
                                end
                            end
                        end
                    end
                end
                default: begin
                    o_Flash_nCS <= 1'b1;
                    o_CMDBusy   <= 1'b0;
                    state       <= StIdle;
                end
            endcase
        end
    end

    // Mode 0 idles with the serial clock low while deselected
    deselectedIdle: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        o_Flash_nCS |-> !o_Flash_Clk && !o_CMDBusy);

endmodule

// File: hdl/flashBusInterface.sv
`timescale 1ns/1ps
`include "flash_defs.svh"

module flashBusInterface import flashPkg::*; (
    input  logic                      i_Clk,
    input  logic                      i_rstN,
    input  logic                      i_SlaveSel,
    input  logic [`REG_ADDR_BITS-1:0] i_RegAddr,
    input  logic [3:0]                i_ByteEn,
    input  logic                      i_Read,
    input  logic                      i_Write,
    input  logic [31:0]               i_WriteData,
    output logic [31:0]               o_ReadData,
    output logic                      o_Flash_Clk,
    output logic                      o_Flash_nCS,
    inout  wire  [3:0]                io_Flash_IO
);

    flashCmd_t   cmdReg;
    flashCmd_t   launchCmd;
    logic [23:0] addrReg;
    flashReq_t   reqReg;
    ctrlWrite_t  ctrlWr;
    ctrlStatus_t ctrlStat;
    logic        regWrite;
    logic        regRead;
    logic        launch;
    logic        startPulse;
    logic        streaming;
    logic        reqSeen;
    logic        cmdBusy;
    logic        reqNextData;
    logic [7:0]  ctrlReadData;
    logic        fifoWrEn;
    logic        fifoRdEn;
    logic [7:0]  fifoDout;
    logic        fifoFull;
    logic        fifoEmpty;

    assign regWrite  = i_SlaveSel && i_Write;
    assign regRead   = i_SlaveSel && i_Read;
    assign ctrlWr    = i_WriteData;
    assign launchCmd = i_ByteEn[0] ? ctrlWr.cmd : cmdReg;
    // Starts while the controller is busy are dropped
    assign launch    = regWrite && (i_RegAddr == `REG_CNTRL) && i_ByteEn[1]
                       && ctrlWr.start && !cmdBusy && !startPulse;

    assign fifoWrEn = regWrite && (i_RegAddr == `REG_DATA) && i_ByteEn[0];
    // One pop per new data request
    assign fifoRdEn = streaming && reqNextData && !reqSeen && !fifoEmpty;

    always_comb begin
        ctrlStat              = '0;
        ctrlStat.fifoEmpty    = fifoEmpty;
        ctrlStat.fifoFull     = fifoFull;
        ctrlStat.cmdBusy      = cmdBusy;
        ctrlStat.startPending = startPulse;
        ctrlStat.cmd          = cmdReg;
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            cmdReg     <= CmdWriteEnable;
            addrReg    <= '0;
            startPulse <= 1'b0;
            streaming  <= 1'b0;
            reqSeen    <= 1'b0;
            o_ReadData <= '0;
        end else begin
            startPulse <= launch;
            reqSeen    <= reqNextData;
            o_ReadData <= '0;
            if (regWrite && i_RegAddr == `REG_CNTRL && i_ByteEn[0]) begin
                cmdReg <= ctrlWr.cmd;
            end
            if (regWrite && i_RegAddr == `REG_ADDR) begin
                for (int lane = 0; lane < 3; lane++) begin
                    if (i_ByteEn[lane]) begin
                        addrReg[8*lane +: 8] <= i_WriteData[8*lane +: 8];
                    end
                end
            end
            if (launch) begin
                reqReg.cmd  <= launchCmd;
                reqReg.addr <= addrReg;
                // Commands with outgoing data bytes feed from the FIFO
                if (launchCmd == CmdProgramPage || launchCmd == CmdWriteStatus) begin
                    streaming <= 1'b1;
                end
            end
            if (streaming && reqNextData && !reqSeen && fifoEmpty) begin
                streaming <= 1'b0;
            end
            if (regRead) begin
                case (i_RegAddr)
                    `REG_CNTRL: o_ReadData <= ctrlStat;
                    `REG_ADDR:  o_ReadData <= {8'h00, addrReg};
                    `REG_DATA:  o_ReadData <= {24'h000000, ctrlReadData};
                    default:    o_ReadData <= '0;
                endcase
            end
        end
    end

    flashWriteFifo fifo0 (
        .i_Clk   (i_Clk),
        .i_rstN  (i_rstN),
        .i_Din   (i_WriteData[7:0]),
        .i_WrEn  (fifoWrEn),
        .i_RdEn  (fifoRdEn),
        .o_Dout  (fifoDout),
        .o_Full  (fifoFull),
        .o_Empty (fifoEmpty)
    );

    flashController ctrl0 (
        .i_Clk         (i_Clk),
        .i_rstN        (i_rstN),
        .i_Start       (startPulse),
        .i_Req         (reqReg),
        .i_WriteData   (fifoDout),
        .i_AckReq      (streaming),
        .o_ReadData    (ctrlReadData),
        .o_ReqNextData (reqNextData),
        .o_CMDBusy     (cmdBusy),
        .o_Flash_Clk   (o_Flash_Clk),
        .o_Flash_nCS   (o_Flash_nCS),
        .io_Flash_IO   (io_Flash_IO)
    );

    // Busy follows one cycle after every start
    startWhenIdle: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        startPulse |-> !cmdBusy ##1 cmdBusy);

endmodule

// File: test/spiFlashModel.sv
`timescale 1ns/1ps
`include "flash_defs.svh"

module spiFlashModel (
    input  logic       i_Sck,
    input  logic       i_nCs,
    inout  wire  [3:0] io_Io
);

    logic [7:0]  mem [4096];
    logic [5:0]  protBits;
    logic        wel;
    logic [7:0]  opcode;
    logic [23:0] addr;
    logic [7:0]  inByte;
    logic [7:0]  outByte;
    logic        misoBit;
    logic        lastSck;
    logic        lastCs;
    int          bitCount;

    assign io_Io[1] = misoBit;

    // Mode 0 captures MOSI on the rising serial clock
    task automatic risingEdge();
        inByte   = {inByte[6:0], io_Io[0]};
        bitCount = bitCount + 1;
        if (bitCount == 8) begin
            opcode = inByte;
            if (opcode == `OP_RDSR) begin
                outByte = {protBits, wel, 1'b0};
            end
        end else if (bitCount <= 32) begin
            addr = {addr[22:0], io_Io[0]};
            if (bitCount == 32 && opcode == `OP_READ) begin
                outByte = mem[addr[11:0]];
            end
        end else if (opcode == `OP_PP && bitCount % 8 == 0) begin
            // Programming only clears bits
            if (wel) begin
                mem[addr[11:0]] = mem[addr[11:0]] & inByte;
            end
            addr = addr + 24'd1;
        end
    endtask

    task automatic finishCommand();
        case (opcode)
            `OP_WREN: begin
                if (bitCount == 8) begin
                    wel = 1'b1;
                end
            end
            `OP_SE, `OP_BE, `OP_CE: begin
                if (wel && bitCount == ((opcode == `OP_CE) ? 8 : 32)) begin
                    // Whole array is smaller than one sector
                    for (int i = 0; i < 4096; i++) begin
                        mem[i[11:0]] = 8'hFF;
                    end
                end
                wel = 1'b0;
            end
            `OP_PP: wel = 1'b0;
            `OP_WRSR: begin
                if (wel && bitCount == 16) begin
                    protBits = inByte[7:2];
                end
                wel = 1'b0;
            end
            default: ;
        endcase
    endtask

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i[11:0]] = 8'hFF;
        end
        protBits = '0;
        wel      = 1'b0;
        opcode   = '0;
        addr     = '0;
        inByte   = '0;
        outByte  = '0;
        misoBit  = 1'b0;
        lastSck  = 1'b0;
        lastCs   = 1'b1;
        bitCount = 0;
        forever begin
            @(i_Sck or i_nCs);
            if (i_nCs === 1'b1 && lastCs === 1'b0) begin
                finishCommand();
            end else if (i_nCs === 1'b0 && lastCs === 1'b1) begin
                bitCount = 0;
            end else if (i_nCs === 1'b0 && i_Sck === 1'b1 && lastSck === 1'b0) begin
                risingEdge();
            end else if (i_nCs === 1'b0 && i_Sck === 1'b0 && lastSck === 1'b1) begin
                misoBit = outByte[7];
                outByte = {outByte[6:0], 1'b0};
            end
            lastSck = i_Sck;
            lastCs  = i_nCs;
        end
    end

endmodule

// File: test/flashTb.sv
`timescale 1ns/1ps
`include "flash_defs.svh"

module flashTb import flashPkg::*; ();

    logic                      clk;
    logic                      rstN;
    logic                      slaveSel;
    logic [`REG_ADDR_BITS-1:0] regAddr;
    logic [3:0]                byteEn;
    logic                      rd;
    logic                      wr;
    logic [31:0]               wrData;
    logic [31:0]               rdData;
    logic                      flashClk;
    logic                      flashNcs;
    wire  [3:0]                flashIo;

    logic [7:0]  mirrorMem [4096];
    logic        mirrorWel;
    logic [7:0]  pageData [`FLASH_FIFO_DEPTH];
    int          pageLen;
    logic [31:0] lcgState;
    logic [31:0] word;
    logic [7:0]  rndByte;

    flashBusInterface dut0 (
        .i_Clk       (clk),
        .i_rstN      (rstN),
        .i_SlaveSel  (slaveSel),
        .i_RegAddr   (regAddr),
        .i_ByteEn    (byteEn),
        .i_Read      (rd),
        .i_Write     (wr),
        .i_WriteData (wrData),
        .o_ReadData  (rdData),
        .o_Flash_Clk (flashClk),
        .o_Flash_nCS (flashNcs),
        .io_Flash_IO (flashIo)
    );

    spiFlashModel flash0 (
        .i_Sck (flashClk),
        .i_nCs (flashNcs),
        .io_Io (flashIo)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected flash byte after a command touches it
    function automatic logic [7:0] refByte(input flashCmd_t cmd, input logic wel,
                                           input logic [7:0] oldByte, input logic [7:0] data);
        if (!wel) begin
            return oldByte;
        end
        case (cmd)
            CmdSectorErase, CmdBlockErase, CmdChipErase: return 8'hFF;
            CmdProgramPage: return oldByte & data;
            default: return oldByte;
        endcase
    endfunction

    function automatic logic [31:0] statusWord(input logic empty, input logic full,
                                               input flashCmd_t cmd);
        ctrlStatus_t stat;
        stat           = '0;
        stat.fifoEmpty = empty;
        stat.fifoFull  = full;
        stat.cmd       = cmd;
        return stat;
    endfunction

    function automatic logic [31:0] ctrlWord(input flashCmd_t cmd);
        ctrlWrite_t ctrl;
        ctrl       = '0;
        ctrl.start = 1'b1;
        ctrl.cmd   = cmd;
        return ctrl;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Value check stopped the run");
        end
    endtask

    task automatic nextRandomByte(output logic [7:0] value);
        lcgState = lcgStep(lcgState);
        value    = lcgState[23:16];
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task automatic busWrite(input logic [`REG_ADDR_BITS-1:0] a, input logic [3:0] be,
                            input logic [31:0] data);
        slaveSel = 1'b1;
        wr       = 1'b1;
        regAddr  = a;
        byteEn   = be;
        wrData   = data;
        @(posedge clk);
        #1;
        slaveSel = 1'b0;
        wr       = 1'b0;
    endtask

    task automatic busRead(input logic [`REG_ADDR_BITS-1:0] a, output logic [31:0] data);
        slaveSel = 1'b1;
        rd       = 1'b1;
        regAddr  = a;
        @(posedge clk);
        #1;
        slaveSel = 1'b0;
        rd       = 1'b0;
        data     = rdData;
    endtask

    task automatic waitIdle();
        ctrlStatus_t stat;
        logic [31:0] status;
        int          cycles;
        cycles = 0;
        do begin
            busRead(`REG_CNTRL, status);
            stat   = ctrlStatus_t'(status);
            cycles = cycles + 1;
            if (cycles > 2000) begin
                $display("Timeout waiting for the flash command to finish");
                $display("Testbench failed");
                $fatal(1, "Busy poll timed out");
            end
        end while (stat.cmdBusy || stat.startPending);
    endtask

    task automatic startCommand(input flashCmd_t cmd, input logic [23:0] addr);
        busWrite(`REG_ADDR, 4'b0111, {8'h00, addr});
        busWrite(`REG_CNTRL, 4'b0011, ctrlWord(cmd));
    endtask

    task automatic runCommand(input flashCmd_t cmd, input logic [23:0] addr);
        logic [11:0] idx;
        startCommand(cmd, addr);
        waitIdle();
        case (cmd)
            CmdWriteEnable: mirrorWel = 1'b1;
            CmdSectorErase, CmdBlockErase, CmdChipErase: begin
                for (int i = 0; i < 4096; i++) begin
                    mirrorMem[i[11:0]] = refByte(cmd, mirrorWel, mirrorMem[i[11:0]], 8'h00);
                end
                mirrorWel = 1'b0;
            end
            CmdProgramPage: begin
                for (int i = 0; i < pageLen; i++) begin
                    idx            = addr[11:0] + i[11:0];
                    mirrorMem[idx] = refByte(cmd, mirrorWel, mirrorMem[idx], pageData[i[3:0]]);
                end
                mirrorWel = 1'b0;
            end
            CmdWriteStatus: mirrorWel = 1'b0;
            default: ;
        endcase
    endtask

    task automatic checkFlashByte(input string name, input logic [23:0] addr);
        logic [31:0] data;
        runCommand(CmdRead, addr);
        busRead(`REG_DATA, data);
        checkValue(name, {24'h000000, mirrorMem[addr[11:0]]}, data);
    endtask

    task automatic checkWel(input string name);
        logic [31:0] data;
        runCommand(CmdReadStatus, 24'h000000);
        busRead(`REG_DATA, data);
        checkValue(name, {24'h000000, 6'd0, mirrorWel, 1'b0}, data);
    endtask

    task automatic pushPageByte();
        nextRandomByte(rndByte);
        pageData[pageLen[3:0]] = rndByte;
        pageLen                = pageLen + 1;
        busWrite(`REG_DATA, 4'b0001, {24'h000000, rndByte});
    endtask

    initial begin
        rstN      = 1'b0;
        slaveSel  = 1'b0;
        regAddr   = '0;
        byteEn    = '0;
        rd        = 1'b0;
        wr        = 1'b0;
        wrData    = '0;
        lcgState  = 32'h60c3_2713;
        mirrorWel = 1'b0;
        pageLen   = 0;
        for (int i = 0; i < 4096; i++) begin
            mirrorMem[i[11:0]] = 8'hFF;
        end
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Registers after reset and byte lane writes
        busRead(`REG_CNTRL, word);
        checkValue("reset status", statusWord(1'b1, 1'b0, CmdWriteEnable), word);
        busWrite(`REG_ADDR, 4'b1111, 32'hFFA5_5A3C);
        busRead(`REG_ADDR, word);
        checkValue("address full write", 32'h00A5_5A3C, word);
        busWrite(`REG_ADDR, 4'b0010, 32'h1234_7156);
        busRead(`REG_ADDR, word);
        checkValue("address lane write", 32'h00A5_713C, word);
        busWrite(`REG_CNTRL, 4'b0001, 32'h0000_0106);
        busRead(`REG_CNTRL, word);
        checkValue("command write", statusWord(1'b1, 1'b0, CmdReadStatus), word);

        // Fill the FIFO
        for (int i = 0; i < `FLASH_FIFO_DEPTH; i++) begin
            pushPageByte();
        end
        busRead(`REG_CNTRL, word);
        checkValue("fifo full status", statusWord(1'b0, 1'b1, CmdReadStatus), word);

        // Program with no write enable drains the FIFO into nothing
        runCommand(CmdProgramPage, 24'h000100);
        busRead(`REG_CNTRL, word);
        checkValue("fifo drained", statusWord(1'b1, 1'b0, CmdProgramPage), word);
        for (int i = 0; i < `FLASH_FIFO_DEPTH; i++) begin
            checkFlashByte("program without wren", 24'h000100 + 24'(i));
        end

        // Erase then page program
        runCommand(CmdWriteEnable, 24'h000000);
        runCommand(CmdSectorErase, 24'h000000);
        runCommand(CmdWriteEnable, 24'h000000);
        pageLen = 0;
        for (int i = 0; i < 8; i++) begin
            pushPageByte();
        end
        runCommand(CmdProgramPage, 24'h000240);
        for (int i = 0; i < 8; i++) begin
            checkFlashByte("page program", 24'h000240 + 24'(i));
        end

        // Second start lands while the read is still running
        startCommand(CmdRead, 24'h000240);
        startCommand(CmdWriteEnable, 24'h000245);
        waitIdle();
        busRead(`REG_DATA, word);
        checkValue("dropped start data", {24'h000000, mirrorMem[12'h240]}, word);
        checkWel("dropped start wel");

        // Write enable latch across an erase
        runCommand(CmdWriteEnable, 24'h000000);
        checkWel("wel after wren");
        runCommand(CmdSectorErase, 24'h000000);
        checkWel("wel after erase");
        for (int i = 0; i < 8; i++) begin
            checkFlashByte("erase", 24'h000240 + 24'(i));
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hdl/flashPkg.sv
hdl/flashWriteFifo.sv
hdl/flashController.sv
hdl/flashBusInterface.sv
test/spiFlashModel.sv
test/flashTb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module flashTb -f all.f -o flashTb

./obj_dir/flashTb
